/* common/ahb3_sram_pkg.sv */
// Shared geometry, AHB3 encodings and enums for the SRAM tile, referenced by scoped name
package ahb3_sram_pkg;

  //////////////////////////////////////////////////
  // Bus and memory geometry
  //////////////////////////////////////////////////

  // Byte address width of the AHB3 bus
  localparam int ADDR_W    = 16;
  // Data bus and byte lanes
  localparam int DATA_W    = 32;
  localparam int STRB_W    = 4;
  // Memory depth in words and word address width
  localparam int MEM_WORDS = 1024;
  localparam int WORD_AW   = 10;
  // First byte address past the memory
  localparam int MEM_BYTES = 4096;

  //////////////////////////////////////////////////
  // AHB3 encodings
  //////////////////////////////////////////////////

  // HTRANS
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // HBURST, standard AMBA numbering
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_e;

  // HSIZE, only up to word on this bus
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  // HRESP for AHB3-Lite
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

endpackage

/* ahb3_slave/ahb3_burst_addr.sv */
// Burst address predictor, tells the AHB3 slave controller where the next SEQ beat must land
`timescale 1ns/1ps

module ahb3_burst_addr (
  input  logic                             ahb3_clk_i,
  input  logic                             reset_i,
  input  logic                             start_i,
  input  logic                             advance_i,
  input  logic [ahb3_sram_pkg::ADDR_W-1:0] addr_i,
  input  ahb3_sram_pkg::hburst_e           hburst_i,
  input  ahb3_sram_pkg::hsize_e            hsize_i,
  output logic [ahb3_sram_pkg::ADDR_W-1:0] pred_addr_o
);

  // Burst attributes held for the whole burst
  ahb3_sram_pkg::hburst_e burst_q;
  ahb3_sram_pkg::hsize_e  size_q;

  //////////////////////////////////////////////////
  // Next beat address
  //////////////////////////////////////////////////

  function automatic logic [ahb3_sram_pkg::ADDR_W-1:0] step_addr(
    input logic [ahb3_sram_pkg::ADDR_W-1:0] a,
    input ahb3_sram_pkg::hburst_e           b,
    input ahb3_sram_pkg::hsize_e            s
  );
    logic [ahb3_sram_pkg::ADDR_W-1:0] inc;
    logic [ahb3_sram_pkg::ADDR_W-1:0] mask;
    // Step is the transfer size in bytes
    inc = 1;
    inc = inc << s;
    // Wrap boundary is beats times size
    case (b)
      ahb3_sram_pkg::WRAP4:  mask = (inc << 2) - 1'b1;
      ahb3_sram_pkg::WRAP8:  mask = (inc << 3) - 1'b1;
      ahb3_sram_pkg::WRAP16: mask = (inc << 4) - 1'b1;
      // Linear, all bits may move
      default:               mask = '1;
    endcase
    // Upper bits stay, low bits roll inside the boundary
    return (a & ~mask) | ((a + inc) & mask);
  endfunction

  //////////////////////////////////////////////////
  // Prediction register
  //////////////////////////////////////////////////

  always_ff @(posedge ahb3_clk_i) begin
    if (reset_i) begin
      burst_q     <= ahb3_sram_pkg::SINGLE;
      size_q      <= ahb3_sram_pkg::BYTE;
      pred_addr_o <= '0;
    end else if (start_i) begin
      // First beat opens a new burst
      burst_q     <= hburst_i;
      size_q      <= hsize_i;
      pred_addr_o <= step_addr(addr_i, hburst_i, hsize_i);
    end else if (advance_i) begin
      pred_addr_o <= step_addr(pred_addr_o, burst_q, size_q);
    end
  end

endmodule

/* ahb3_slave/ahb3_slave_ctrl.sv */
// AHB3-Lite slave controller for the SRAM, instanced by the top next to the burst generator
`timescale 1ns/1ps

module ahb3_slave_ctrl (
  input  logic                              ahb3_clk_i,
  input  logic                              reset_i,
  // AHB3 slave side
  input  logic                              hsel_i,
  input  logic [ahb3_sram_pkg::ADDR_W-1:0]  haddr_i,
  input  ahb3_sram_pkg::htrans_e            htrans_i,
  input  logic                              hwrite_i,
  input  ahb3_sram_pkg::hsize_e             hsize_i,
  input  ahb3_sram_pkg::hburst_e            hburst_i,
  input  logic [ahb3_sram_pkg::DATA_W-1:0]  hwdata_i,
  output logic                              hready_o,
  output ahb3_sram_pkg::hresp_e             hresp_o,
  // Burst generator side
  output logic                              burst_start_o,
  output logic                              burst_advance_o,
  input  logic [ahb3_sram_pkg::ADDR_W-1:0]  pred_addr_i,
  // Memory side
  output logic                              mem_we_o,
  output logic [ahb3_sram_pkg::STRB_W-1:0]  mem_be_o,
  output logic [ahb3_sram_pkg::WORD_AW-1:0] mem_waddr_o,
  output logic [ahb3_sram_pkg::DATA_W-1:0]  mem_wdata_o,
  output logic                              mem_re_o,
  output logic [ahb3_sram_pkg::WORD_AW-1:0] mem_raddr_o
);

  // Response FSM
  typedef enum logic [1:0] {ST_OKAY, ST_WAIT, ST_ERR1, ST_ERR2} state_e;

  state_e                             state_q;
  state_e                             state_d;
  logic                               accept;
  logic                               out_of_range;
  logic                               bad_burst;
  logic                               err;
  logic                               wr_ending;
  logic [ahb3_sram_pkg::WORD_AW-1:0]  live_word;
  // Held address phase
  logic                               ap_valid;
  logic                               ap_write;
  logic [ahb3_sram_pkg::WORD_AW-1:0]  ap_word;
  ahb3_sram_pkg::hsize_e              ap_size;
  logic [1:0]                         ap_offset;

  //////////////////////////////////////////////////
  // Address phase decode
  //////////////////////////////////////////////////

  // Only NONSEQ and SEQ count, IDLE and BUSY pass with OKAY
  assign accept = hready_o & hsel_i &
                  ((htrans_i == ahb3_sram_pkg::NONSEQ) | (htrans_i == ahb3_sram_pkg::SEQ));
  assign live_word = haddr_i[ahb3_sram_pkg::WORD_AW+1:2];
  assign out_of_range = (haddr_i >= ahb3_sram_pkg::MEM_BYTES);
  // SEQ must hit the predicted address, and never belongs to a SINGLE
  assign bad_burst = (htrans_i == ahb3_sram_pkg::SEQ) &
                     ((haddr_i != pred_addr_i) | (hburst_i == ahb3_sram_pkg::SINGLE));
  assign err = out_of_range | bad_burst;

  // Burst generator follows every accepted beat
  assign burst_start_o   = accept & (htrans_i == ahb3_sram_pkg::NONSEQ);
  assign burst_advance_o = accept & (htrans_i == ahb3_sram_pkg::SEQ) & ~err;

  // Write data phase closing at this edge
  assign wr_ending = ap_valid & ap_write & (state_q == ST_OKAY);

  // Capture the address phase whenever the previous data phase ends
  always_ff @(posedge ahb3_clk_i) begin
    if (reset_i) begin
      ap_valid <= 1'b0;
      ap_write <= 1'b0;
    end else if (hready_o) begin
      // Errored beats leave no data phase behind
      ap_valid <= accept & ~err;
      ap_write <= hwrite_i;
    end
  end

  // Payload part of the held phase
  always_ff @(posedge ahb3_clk_i) begin
    if (accept) begin
      ap_word   <= live_word;
      ap_size   <= hsize_i;
      ap_offset <= haddr_i[1:0];
    end
  end

  //////////////////////////////////////////////////
  // Response FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_OKAY, ST_ERR2: begin
        if (accept & err) begin
          state_d = ST_ERR1;
        end else if (accept & ~hwrite_i & wr_ending) begin
          // Read behind a write waits for the write to land
          state_d = ST_WAIT;
        end else begin
          state_d = ST_OKAY;
        end
      end
      ST_WAIT: state_d = ST_OKAY;
      ST_ERR1: state_d = ST_ERR2;
      default: state_d = ST_OKAY;
    endcase
  end

  always_ff @(posedge ahb3_clk_i) begin
    if (reset_i) begin
      state_q <= ST_OKAY;
    end else begin
      state_q <= state_d;
    end
  end

  // Two-cycle ERROR, first cycle stalled
  assign hready_o = (state_q == ST_OKAY) | (state_q == ST_ERR2);
  assign hresp_o  = ((state_q == ST_ERR1) | (state_q == ST_ERR2)) ?
                    ahb3_sram_pkg::ERROR : ahb3_sram_pkg::OKAY;

  //////////////////////////////////////////////////
  // Memory requests
  //////////////////////////////////////////////////

  // Byte lanes from held size and offset
  always_comb begin
    case (ap_size)
      ahb3_sram_pkg::BYTE: mem_be_o = 4'b0001 << ap_offset;
      ahb3_sram_pkg::HALF: mem_be_o = 4'b0011 << {ap_offset[1], 1'b0};
      default:             mem_be_o = 4'b1111;
    endcase
  end

  // Write lands at the edge ending its data phase
  assign mem_we_o    = wr_ending;
  assign mem_waddr_o = ap_word;
  assign mem_wdata_o = hwdata_i;

  // Live read unless a write lands now, held read in the wait cycle
  assign mem_re_o    = (state_q == ST_WAIT) |
                       (accept & ~hwrite_i & ~err & ~wr_ending);
  assign mem_raddr_o = (state_q == ST_WAIT) ? ap_word : live_word;

endmodule

/* design/sram_array.sv */
// Word-wide SRAM with byte-lane writes and a registered read, placed behind the AHB3 controller
`timescale 1ns/1ps

module sram_array #(
  parameter int WORDS = ahb3_sram_pkg::MEM_WORDS
) (
  input  logic                              ahb3_clk_i,
  // Write port
  input  logic                              we_i,
  input  logic [ahb3_sram_pkg::STRB_W-1:0]  be_i,
  input  logic [ahb3_sram_pkg::WORD_AW-1:0] waddr_i,
  input  logic [ahb3_sram_pkg::DATA_W-1:0]  wdata_i,
  // Read port
  input  logic                              re_i,
  input  logic [ahb3_sram_pkg::WORD_AW-1:0] raddr_i,
  output logic [ahb3_sram_pkg::DATA_W-1:0]  rdata_o
);

  // Storage, contents undefined until written
  logic [ahb3_sram_pkg::DATA_W-1:0] mem [WORDS];

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  // One enable per byte lane
  always_ff @(posedge ahb3_clk_i) begin
    if (we_i) begin
      for (int b = 0; b < ahb3_sram_pkg::STRB_W; b++) begin
        if (be_i[b]) begin
          mem[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  // Output holds between reads
  always_ff @(posedge ahb3_clk_i) begin
    if (re_i) begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

/* design/ahb3_sram_top.sv */
// AHB3-Lite SRAM tile top, connects the slave controller, burst predictor and memory to the pins
`timescale 1ns/1ps

module ahb3_sram_top (
  input  logic                             ahb3_clk_i,
  input  logic                             reset_i,
  // AHB3 master inputs
  input  logic                             hsel_i,
  input  logic [ahb3_sram_pkg::ADDR_W-1:0] haddr_i,
  input  ahb3_sram_pkg::htrans_e           htrans_i,
  input  logic                             hwrite_i,
  input  ahb3_sram_pkg::hsize_e            hsize_i,
  input  ahb3_sram_pkg::hburst_e           hburst_i,
  input  logic [ahb3_sram_pkg::DATA_W-1:0] hwdata_i,
  // AHB3 slave outputs
  output logic                             hready_o,
  output ahb3_sram_pkg::hresp_e            hresp_o,
  output logic [ahb3_sram_pkg::DATA_W-1:0] hrdata_o
);

  // Controller to burst predictor
  logic                              burst_start;
  logic                              burst_advance;
  logic [ahb3_sram_pkg::ADDR_W-1:0]  pred_addr;
  // Controller to memory
  logic                              mem_we;
  logic [ahb3_sram_pkg::STRB_W-1:0]  mem_be;
  logic [ahb3_sram_pkg::WORD_AW-1:0] mem_waddr;
  logic [ahb3_sram_pkg::DATA_W-1:0]  mem_wdata;
  logic                              mem_re;
  logic [ahb3_sram_pkg::WORD_AW-1:0] mem_raddr;

  //////////////////////////////////////////////////
  // Slave controller
  //////////////////////////////////////////////////

  ahb3_slave_ctrl ctrl0 (
    .ahb3_clk_i      (ahb3_clk_i),
    .reset_i         (reset_i),
    .hsel_i          (hsel_i),
    .haddr_i         (haddr_i),
    .htrans_i        (htrans_i),
    .hwrite_i        (hwrite_i),
    .hsize_i         (hsize_i),
    .hburst_i        (hburst_i),
    .hwdata_i        (hwdata_i),
    .hready_o        (hready_o),
    .hresp_o         (hresp_o),
    .burst_start_o   (burst_start),
    .burst_advance_o (burst_advance),
    .pred_addr_i     (pred_addr),
    .mem_we_o        (mem_we),
    .mem_be_o        (mem_be),
    .mem_waddr_o     (mem_waddr),
    .mem_wdata_o     (mem_wdata),
    .mem_re_o        (mem_re),
    .mem_raddr_o     (mem_raddr)
  );

  // Predictor sees the live address phase pins
  ahb3_burst_addr burst0 (
    .ahb3_clk_i  (ahb3_clk_i),
    .reset_i     (reset_i),
    .start_i     (burst_start),
    .advance_i   (burst_advance),
    .addr_i      (haddr_i),
    .hburst_i    (hburst_i),
    .hsize_i     (hsize_i),
    .pred_addr_o (pred_addr)
  );

  //////////////////////////////////////////////////
  // Memory
  //////////////////////////////////////////////////

  // Read data goes straight out as HRDATA
  sram_array #(
    .WORDS (ahb3_sram_pkg::MEM_WORDS)
  ) mem0 (
    .ahb3_clk_i (ahb3_clk_i),
    .we_i       (mem_we),
    .be_i       (mem_be),
    .waddr_i    (mem_waddr),
    .wdata_i    (mem_wdata),
    .re_i       (mem_re),
    .raddr_i    (mem_raddr),
    .rdata_o    (hrdata_o)
  );

endmodule

/* sim/ahb3_sram_assertions.sv */
// Concurrent AHB3 protocol checks, bound into every ahb3_slave_ctrl instance
`timescale 1ns/1ps

module ahb3_sram_assertions (
  input logic                              ahb3_clk_i,
  input logic                              reset_i,
  input logic                              hready_o,
  input ahb3_sram_pkg::hresp_e             hresp_o,
  input logic                              mem_we_o,
  input logic [ahb3_sram_pkg::WORD_AW-1:0] mem_waddr_o,
  input logic                              mem_re_o,
  input logic [ahb3_sram_pkg::WORD_AW-1:0] mem_raddr_o
);

  // Failed assertion count
  int fail_count = 0;

  //////////////////////////////////////////////////
  // Response sequencing
  //////////////////////////////////////////////////

  // Ready straight out of reset
  a_ready_after_reset: assert property (@(posedge ahb3_clk_i) reset_i |=> hready_o)
    else begin
      $error("hready_o low in the first cycle after reset");
      fail_count++;
    end

  // Stalled ERROR always closes with a ready ERROR
  a_error_two_cycle: assert property (@(posedge ahb3_clk_i) disable iff (reset_i)
    (!hready_o && hresp_o == ahb3_sram_pkg::ERROR) |=>
    (hready_o && hresp_o == ahb3_sram_pkg::ERROR))
    else begin
      $error("ERROR response not followed by a ready ERROR cycle");
      fail_count++;
    end

  // Single wait state
  a_one_wait: assert property (@(posedge ahb3_clk_i) disable iff (reset_i)
    (!hready_o && hresp_o == ahb3_sram_pkg::OKAY) |=> hready_o)
    else begin
      $error("hready_o low for more than one cycle outside ERROR");
      fail_count++;
    end

  // No read and write of one word in the same cycle
  a_no_rw_clash: assert property (@(posedge ahb3_clk_i) disable iff (reset_i)
    !(mem_we_o && mem_re_o && mem_waddr_o == mem_raddr_o))
    else begin
      $error("Read and write of the same word in one cycle");
      fail_count++;
    end

endmodule

bind ahb3_slave_ctrl ahb3_sram_assertions asrt0 (
  .ahb3_clk_i  (ahb3_clk_i),
  .reset_i     (reset_i),
  .hready_o    (hready_o),
  .hresp_o     (hresp_o),
  .mem_we_o    (mem_we_o),
  .mem_waddr_o (mem_waddr_o),
  .mem_re_o    (mem_re_o),
  .mem_raddr_o (mem_raddr_o)
);

/* sim/ahb3_sram_tb.sv */
// Self-checking testbench for the AHB3 SRAM tile, random AHB3 master traffic against a byte model
`timescale 1ns/1ps

module ahb3_sram_tb;

  localparam int CLK_PERIOD = 20;
  localparam int N_SINGLE   = 300;
  localparam int N_BURST    = 60;
  localparam int N_BADADDR  = 12;
  localparam int N_RANGE    = 12;
  localparam int N_RAW      = 80;
  // Beat estimate, bursts count a write and a read pass of up to 16 beats
  localparam int N_TXN = ahb3_sram_pkg::MEM_WORDS + N_SINGLE + N_BURST * 32 +
                         N_BADADDR * 6 + N_RANGE * 2 + N_RAW * 4;

  typedef logic [ahb3_sram_pkg::ADDR_W-1:0] addr_t;
  typedef logic [ahb3_sram_pkg::DATA_W-1:0] data_t;

  // One address phase plus what its data phase should bring
  typedef struct packed {
    addr_t                  addr;
    logic                   write;
    ahb3_sram_pkg::hsize_e  size;
    ahb3_sram_pkg::hburst_e burst;
    ahb3_sram_pkg::htrans_e trans;
    data_t                  wdata;
    ahb3_sram_pkg::hresp_e  resp;
  } beat_t;

  logic                   ahb3_clk_i;
  logic                   reset_i;
  logic                   hsel_i;
  addr_t                  haddr_i;
  ahb3_sram_pkg::htrans_e htrans_i;
  logic                   hwrite_i;
  ahb3_sram_pkg::hsize_e  hsize_i;
  ahb3_sram_pkg::hburst_e hburst_i;
  data_t                  hwdata_i;
  logic                   hready_o;
  ahb3_sram_pkg::hresp_e  hresp_o;
  data_t                  hrdata_o;

  beat_t      beats [$];
  // Reference memory, one entry per byte address
  logic [7:0] model [ahb3_sram_pkg::MEM_BYTES];

  ahb3_sram_top dut0 (
    .ahb3_clk_i (ahb3_clk_i),
    .reset_i    (reset_i),
    .hsel_i     (hsel_i),
    .haddr_i    (haddr_i),
    .htrans_i   (htrans_i),
    .hwrite_i   (hwrite_i),
    .hsize_i    (hsize_i),
    .hburst_i   (hburst_i),
    .hwdata_i   (hwdata_i),
    .hready_o   (hready_o),
    .hresp_o    (hresp_o),
    .hrdata_o   (hrdata_o)
  );

  initial begin
    ahb3_clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) ahb3_clk_i = ~ahb3_clk_i;
  end

  // Watchdog
  initial begin
    #(N_TXN * 40 * CLK_PERIOD);
    $display("Timeout: the run took longer than the allowed time");
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_rdata(input data_t got, input data_t exp,
                             input logic [ahb3_sram_pkg::STRB_W-1:0] lanes);
    data_t mask;
    for (int b = 0; b < ahb3_sram_pkg::STRB_W; b++) begin
      mask[8*b +: 8] = {8{lanes[b]}};
    end
    if ((got & mask) !== (exp & mask)) begin
      $display("Mismatch hrdata_o: got %h expected %h lanes %h", got & mask, exp & mask, lanes);
      $display("Simulation failed");
      $fatal(1, "Stopping at the first failing check");
    end
  endtask

  task automatic check_resp(input ahb3_sram_pkg::hresp_e got, input ahb3_sram_pkg::hresp_e exp);
    if (got !== exp) begin
      $display("Mismatch hresp_o: got %h expected %h", got, exp);
      $display("Simulation failed");
      $fatal(1, "Stopping at the first failing check");
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch hready_o: got %h expected %h", got, exp);
      $display("Simulation failed");
      $fatal(1, "Stopping at the first failing check");
    end
  endtask

  //////////////////////////////////////////////////
  // Master and model
  //////////////////////////////////////////////////

  // AHB byte lanes, the transfer's bytes counted from its aligned offset
  function automatic logic [ahb3_sram_pkg::STRB_W-1:0] lanes_of(input addr_t a,
                                                               input ahb3_sram_pkg::hsize_e s);
    logic [ahb3_sram_pkg::STRB_W-1:0] l;
    int                               first;
    int                               nbytes;
    nbytes = 1 << int'(s);
    first  = int'(a[1:0]) & ~(nbytes - 1);
    for (int b = 0; b < ahb3_sram_pkg::STRB_W; b++) begin
      l[b] = (b >= first) && (b < first + nbytes);
    end
    return l;
  endfunction

  // NONSEQ and SEQ carry data, IDLE and BUSY do not
  function automatic logic is_transfer(input beat_t bt);
    return bt.trans == ahb3_sram_pkg::NONSEQ || bt.trans == ahb3_sram_pkg::SEQ;
  endfunction

  // Random address in [lo, hi], aligned to the size
  function automatic addr_t rand_addr(input ahb3_sram_pkg::hsize_e s, input int lo, input int hi);
    return addr_t'(int'($urandom_range(hi, lo)) & ~((1 << int'(s)) - 1));
  endfunction

  task automatic add_beat(input addr_t a, input logic wr, input ahb3_sram_pkg::hsize_e sz,
                          input ahb3_sram_pkg::hburst_e bt, input ahb3_sram_pkg::htrans_e tr,
                          input data_t wd, input ahb3_sram_pkg::hresp_e rs);
    beat_t b;
    b.addr  = a;
    b.write = wr;
    b.size  = sz;
    b.burst = bt;
    b.trans = tr;
    b.wdata = wd;
    b.resp  = rs;
    beats.push_back(b);
  endtask

  // End of an OKAY data phase, writes go to the model and reads are checked
  task automatic finish_beat(input beat_t bt);
    logic [ahb3_sram_pkg::STRB_W-1:0] lanes;
    int                               base;
    data_t                            exp;
    exp = '0;
    if ((bt.trans == ahb3_sram_pkg::NONSEQ || bt.trans == ahb3_sram_pkg::SEQ) &&
        bt.resp == ahb3_sram_pkg::OKAY) begin
      lanes = lanes_of(bt.addr, bt.size);
      base  = int'(bt.addr) & ~3;
      for (int b = 0; b < ahb3_sram_pkg::STRB_W; b++) begin
        if (bt.write && lanes[b]) model[base + b] = bt.wdata[8*b +: 8];
        exp[8*b +: 8] = model[base + b];
      end
      if (!bt.write) check_rdata(hrdata_o, exp, lanes);
    end
  endtask

  task automatic drive_addr(input int idx);
    if (idx < beats.size()) begin
      haddr_i  = beats[idx].addr;
      htrans_i = beats[idx].trans;
      hwrite_i = beats[idx].write;
      hsize_i  = beats[idx].size;
      hburst_i = beats[idx].burst;
    end else begin
      htrans_i = ahb3_sram_pkg::IDLE;
      hwrite_i = 1'b0;
    end
  endtask

  // Pipelined master, outputs sampled at the falling edge before each decision edge
  task automatic run_beats();
    int   ap;
    int   dp;
    int   n;
    int   cyc;
    logic wr_before;
    logic exp_ready;
    n         = beats.size();
    ap        = 0;
    dp        = -1;
    cyc       = 0;
    wr_before = 1'b0;
    drive_addr(0);
    while (dp >= 0 || ap < n) begin
      @(negedge ahb3_clk_i);
      exp_ready = 1'b1;
      if (dp >= 0) begin
        check_resp(hresp_o, beats[dp].resp);
        // First data cycle stalls for ERROR and for a read right behind a write
        if (cyc == 0 && beats[dp].resp == ahb3_sram_pkg::ERROR) begin
          exp_ready = 1'b0;
        end
        if (cyc == 0 && wr_before && !beats[dp].write && is_transfer(beats[dp])) begin
          exp_ready = 1'b0;
        end
      end
      check_ready(hready_o, exp_ready);
      if (hready_o) begin
        if (dp >= 0) finish_beat(beats[dp]);
        // Write still landing when the next data phase opens
        wr_before = (dp >= 0) && beats[dp].write && is_transfer(beats[dp]) &&
                    (beats[dp].resp == ahb3_sram_pkg::OKAY);
        dp  = (ap < n) ? ap : -1;
        ap  = (ap < n) ? ap + 1 : ap;
        cyc = 0;
      end else begin
        cyc++;
        if (hresp_o == ahb3_sram_pkg::ERROR) begin
          // First ERROR cycle, rest of the burst is dropped
          ap = n;
        end
      end
      @(posedge ahb3_clk_i);
      #2;
      if (dp >= 0) begin
        if (beats[dp].write) hwdata_i = beats[dp].wdata;
      end
      drive_addr(ap);
    end
    // Last data phase closes on this rising edge
    @(posedge ahb3_clk_i);
    #2;
    beats.delete();
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic burst_test(input ahb3_sram_pkg::hburst_e bt);
    ahb3_sram_pkg::hsize_e sz;
    int                    len;
    int                    step;
    int                    bnd;
    addr_t                 start;
    addr_t                 a;
    data_t                 wd [16];
    sz   = ahb3_sram_pkg::hsize_e'($urandom_range(0, 2));
    step = 1 << int'(sz);
    case (bt)
      ahb3_sram_pkg::WRAP4, ahb3_sram_pkg::INCR4:   len = 4;
      ahb3_sram_pkg::WRAP8, ahb3_sram_pkg::INCR8:   len = 8;
      ahb3_sram_pkg::WRAP16, ahb3_sram_pkg::INCR16: len = 16;
      default:                                      len = int'($urandom_range(1, 8));
    endcase
    bnd   = len * step;
    start = rand_addr(sz, 0, ahb3_sram_pkg::MEM_BYTES - bnd);
    for (int i = 0; i < len; i++) wd[i] = $urandom();
    // Write pass then read pass over the same beats
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < len; i++) begin
        if (bt == ahb3_sram_pkg::WRAP4 || bt == ahb3_sram_pkg::WRAP8 ||
            bt == ahb3_sram_pkg::WRAP16) begin
          a = addr_t'((int'(start) & ~(bnd - 1)) | ((int'(start) + i * step) & (bnd - 1)));
        end else begin
          a = addr_t'(int'(start) + i * step);
        end
        add_beat(a, p == 0, sz, bt, (i == 0) ? ahb3_sram_pkg::NONSEQ : ahb3_sram_pkg::SEQ,
                 wd[i], ahb3_sram_pkg::OKAY);
      end
    end
    run_beats();
  endtask

  // INCR4 write with one SEQ beat off the predicted address
  task automatic bad_addr_test();
    ahb3_sram_pkg::hsize_e sz;
    int                    step;
    int                    k;
    addr_t                 start;
    addr_t                 a;
    addr_t                 bad;
    sz    = ahb3_sram_pkg::hsize_e'($urandom_range(0, 2));
    step  = 1 << int'(sz);
    k     = int'($urandom_range(1, 3));
    start = rand_addr(sz, 0, ahb3_sram_pkg::MEM_BYTES - 4 * step);
    bad   = '0;
    for (int i = 0; i < 4; i++) begin
      a = addr_t'(int'(start) + i * step);
      if (i == k) begin
        bad = a ^ 16'h0100;
        add_beat(bad, 1'b1, sz, ahb3_sram_pkg::INCR4, ahb3_sram_pkg::SEQ, $urandom(),
                 ahb3_sram_pkg::ERROR);
      end else begin
        add_beat(a, 1'b1, sz, ahb3_sram_pkg::INCR4,
                 (i == 0) ? ahb3_sram_pkg::NONSEQ : ahb3_sram_pkg::SEQ, $urandom(),
                 ahb3_sram_pkg::OKAY);
      end
    end
    run_beats();
    // Neither the wrong nor the predicted word may have changed
    add_beat(bad & 16'hFFFC, 1'b0, ahb3_sram_pkg::WORD, ahb3_sram_pkg::SINGLE,
             ahb3_sram_pkg::NONSEQ, '0, ahb3_sram_pkg::OKAY);
    add_beat(addr_t'(int'(start) + k * step) & 16'hFFFC, 1'b0, ahb3_sram_pkg::WORD,
             ahb3_sram_pkg::SINGLE, ahb3_sram_pkg::NONSEQ, '0, ahb3_sram_pkg::OKAY);
    run_beats();
  endtask

  task automatic range_test();
    ahb3_sram_pkg::hsize_e sz;
    addr_t                 a;
    sz = ahb3_sram_pkg::hsize_e'($urandom_range(0, 2));
    a  = rand_addr(sz, ahb3_sram_pkg::MEM_BYTES, 65535);
    add_beat(a, 1'($urandom_range(0, 1)), sz, ahb3_sram_pkg::SINGLE, ahb3_sram_pkg::NONSEQ,
             $urandom(), ahb3_sram_pkg::ERROR);
    run_beats();
    // Aliased in-range word
    add_beat(a & 16'h0FFC, 1'b0, ahb3_sram_pkg::WORD, ahb3_sram_pkg::SINGLE,
             ahb3_sram_pkg::NONSEQ, '0, ahb3_sram_pkg::OKAY);
    run_beats();
  endtask

  // Write then read of the same word, sometimes with IDLE or BUSY between
  task automatic raw_test();
    ahb3_sram_pkg::hsize_e sz;
    addr_t                 a;
    sz = ahb3_sram_pkg::hsize_e'($urandom_range(0, 2));
    a  = rand_addr(sz, 0, ahb3_sram_pkg::MEM_BYTES - 1);
    add_beat(a, 1'b1, sz, ahb3_sram_pkg::SINGLE, ahb3_sram_pkg::NONSEQ, $urandom(),
             ahb3_sram_pkg::OKAY);
    repeat ($urandom_range(0, 2)) begin
      add_beat(a, 1'b0, ahb3_sram_pkg::WORD, ahb3_sram_pkg::INCR,
               $urandom_range(0, 1) ? ahb3_sram_pkg::BUSY : ahb3_sram_pkg::IDLE, '0,
               ahb3_sram_pkg::OKAY);
    end
    add_beat(a & 16'hFFFC, 1'b0, ahb3_sram_pkg::WORD, ahb3_sram_pkg::SINGLE,
             ahb3_sram_pkg::NONSEQ, '0, ahb3_sram_pkg::OKAY);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    ahb3_sram_pkg::hsize_e sz;
    void'($urandom(16));
    reset_i  = 1'b1;
    hsel_i   = 1'b0;
    haddr_i  = '0;
    htrans_i = ahb3_sram_pkg::IDLE;
    hwrite_i = 1'b0;
    hsize_i  = ahb3_sram_pkg::WORD;
    hburst_i = ahb3_sram_pkg::SINGLE;
    hwdata_i = '0;
    repeat (3) @(posedge ahb3_clk_i);
    #2;
    reset_i = 1'b0;
    hsel_i  = 1'b1;
    // Fill, data built from the whole byte address
    for (int w = 0; w < ahb3_sram_pkg::MEM_WORDS; w++) begin
      add_beat(addr_t'(w * 4), 1'b1, ahb3_sram_pkg::WORD, ahb3_sram_pkg::SINGLE,
               ahb3_sram_pkg::NONSEQ, {addr_t'(w * 4), ~addr_t'(w * 4)}, ahb3_sram_pkg::OKAY);
    end
    run_beats();
    // Random singles in groups of 20
    for (int g = 0; g < N_SINGLE / 20; g++) begin
      repeat (20) begin
        sz = ahb3_sram_pkg::hsize_e'($urandom_range(0, 2));
        add_beat(rand_addr(sz, 0, ahb3_sram_pkg::MEM_BYTES - 1),
                 1'($urandom_range(0, 1)), sz, ahb3_sram_pkg::SINGLE,
                 ahb3_sram_pkg::NONSEQ, $urandom(), ahb3_sram_pkg::OKAY);
      end
      run_beats();
    end
    // INCR..INCR16 and WRAP4..WRAP16, never SINGLE
    repeat (N_BURST) burst_test(ahb3_sram_pkg::hburst_e'($urandom_range(1, 7)));
    repeat (N_BADADDR) bad_addr_test();
    repeat (N_RANGE) range_test();
    for (int g = 0; g < N_RAW / 10; g++) begin
      repeat (10) raw_test();
      run_beats();
    end
    repeat (4) @(posedge ahb3_clk_i);
    if (dut0.ctrl0.asrt0.fail_count != 0) begin
      $display("Protocol assertions failed %0d times", dut0.ctrl0.asrt0.fail_count);
      $display("Simulation failed");
      $fatal(1, "Assertion failures during the run");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

/* all.f */
common/ahb3_sram_pkg.sv
ahb3_slave/ahb3_burst_addr.sv
ahb3_slave/ahb3_slave_ctrl.sv
design/sram_array.sv
design/ahb3_sram_top.sv
sim/ahb3_sram_assertions.sv
sim/ahb3_sram_tb.sv
